// ==== branch_predictor/branch_history_table.sv ====
// ==================================================
// branch history table
// 32 two-bit saturating counters, registered direction read
// ==================================================

`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_history_table (
	input  logic                clk,
	input  logic                reset,
	input  logic                rd_en,
	input  logic [`BP_PC_W-1:0] rd_pc,
	bp_update_if.sink           upd,
	output logic                taken
);
	import bp_pkg::*;

	localparam int ENTRIES = `BP_BHT_ENTRIES;

	counter_state_t              counters [ENTRIES];
	logic [`BP_BHT_IDX_W-1:0]    rd_idx;
	logic [`BP_BHT_IDX_W-1:0]    wr_idx;
	counter_state_t              wr_state;

	// word aligned pcs, so the two low bits are skipped
	assign rd_idx   = rd_pc[`BP_BHT_IDX_W+1:2];
	assign wr_idx   = upd.pc[`BP_BHT_IDX_W+1:2];
	assign wr_state = counters[wr_idx];

	// ==================================================
	// direction read
	// ==================================================

	// nonblocking read, so an update at the same edge is not seen yet
	always_ff @(posedge clk) begin
		if (reset) begin
			taken <= 1'b0;
		end else if (rd_en) begin
			taken <= counters[rd_idx][1]; // msb of the counter is the direction
		end
	end

	// ==================================================
	// counter update
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ENTRIES; i++) begin
				counters[i] <= strongly_not_taken;
			end
		end else if (upd.valid) begin
			case (upd.kind)
				upd_taken, upd_jump: begin
					if (wr_state != strongly_taken)
						counters[wr_idx] <= counter_state_t'(wr_state + 2'd1);
				end
				upd_not_taken: begin
					if (wr_state != strongly_not_taken)
						counters[wr_idx] <= counter_state_t'(wr_state - 2'd1);
				end
				default: begin
					// unknown kind leaves the counter alone
				end
			endcase
		end
	end

	// execute must only report the three defined kinds
	assert property (@(posedge clk) disable iff (reset)
		upd.valid |-> upd.kind inside {upd_not_taken, upd_taken, upd_jump})
		else $error("branch_history_table: unknown update kind %0h", upd.kind);

endmodule

// ==== branch_predictor/branch_target_buffer.sv ====
// ==================================================
// branch target buffer
// 16 direct mapped entries of valid, tag and target
// ==================================================

`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_target_buffer (
	input  logic                clk,
	input  logic                reset,
	input  logic                rd_en,
	input  logic [`BP_PC_W-1:0] rd_pc,
	bp_update_if.sink           upd,
	output logic                hit,
	output logic [`BP_PC_W-1:0] target
);
	import bp_pkg::*;

	localparam int ENTRIES = `BP_BTB_ENTRIES;

	logic                      valid_q  [ENTRIES];
	logic [`BP_BTB_TAG_W-1:0]  tag_q    [ENTRIES];
	logic [`BP_PC_W-1:0]       target_q [ENTRIES];

	logic [`BP_BTB_IDX_W-1:0]  rd_idx;
	logic [`BP_BTB_TAG_W-1:0]  rd_tag;
	logic [`BP_BTB_IDX_W-1:0]  wr_idx;
	logic [`BP_BTB_TAG_W-1:0]  wr_tag;
	logic                      wr_en;

	assign rd_idx = rd_pc[`BP_BTB_IDX_W+1:2];
	assign rd_tag = rd_pc[`BP_PC_W-1:`BP_BTB_IDX_W+2];
	assign wr_idx = upd.pc[`BP_BTB_IDX_W+1:2];
	assign wr_tag = upd.pc[`BP_PC_W-1:`BP_BTB_IDX_W+2];

	// only taken transfers allocate, a fall through has no target to learn
	assign wr_en = upd.valid && (upd.kind == upd_taken || upd.kind == upd_jump);

	// ==================================================
	// lookup
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			hit <= 1'b0;
		end else if (rd_en) begin
			hit <= valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			target <= target_q[rd_idx]; // only meaningful together with hit
		end
	end

	// ==================================================
	// write
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ENTRIES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[wr_idx]    <= wr_tag;
			target_q[wr_idx] <= upd.target;
		end
	end

	// an allocating update must leave its entry valid for the next lookup
	assert property (@(posedge clk) disable iff (reset)
		wr_en |=> valid_q[$past(wr_idx)])
		else $error("branch_target_buffer: entry %0d not valid after write",
			$past(wr_idx));

endmodule

// ==== common/bp_macros.svh ====
// ==================================================
// widths and table sizes of the branch prediction unit
// ==================================================

`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

`define BP_PC_W        32

// history table is indexed by pc bits 6 to 2
`define BP_BHT_IDX_W   5
`define BP_BHT_ENTRIES (1 << `BP_BHT_IDX_W)

// target buffer is indexed by pc bits 5 to 2, the rest above is the tag
`define BP_BTB_IDX_W   4
`define BP_BTB_ENTRIES (1 << `BP_BTB_IDX_W)
`define BP_BTB_TAG_W   (`BP_PC_W - `BP_BTB_IDX_W - 2)

`endif

// ==== common/bp_pkg.sv ====
// ==================================================
// types shared by the branch prediction unit
// counter states and update kinds
// ==================================================

package bp_pkg;

	// two-bit saturating counter, the msb is the predicted direction
	typedef enum logic [1:0] {
		strongly_not_taken = 2'd0,
		weakly_not_taken   = 2'd1,
		weakly_taken       = 2'd2,
		strongly_taken     = 2'd3
	} counter_state_t;

	// kind of a resolved control transfer reported by execute
	typedef enum logic [1:0] {
		upd_not_taken = 2'd0, // conditional branch that fell through
		upd_taken     = 2'd1, // conditional branch that was taken
		upd_jump      = 2'd2  // unconditional jump
	} update_kind_t;

endpackage

// ==== common/bp_update_if.sv ====
// ==================================================
// resolved branch update bus from execute
// ==================================================

`timescale 1ns/100ps

`include "bp_macros.svh"

interface bp_update_if;
	import bp_pkg::*;

	logic               valid;  // no ready, execute never stalls
	logic [`BP_PC_W-1:0] pc;
	update_kind_t       kind;
	logic [`BP_PC_W-1:0] target;

	modport source (
		output valid,
		output pc,
		output kind,
		output target
	);

	modport sink (
		input valid,
		input pc,
		input kind,
		input target
	);

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the branch predictor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bp_tb -f vlog.f -Mdir obj_dir -o bp_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/bp_sim > sim.log 2>&1
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== testbench/bp_tb.sv ====
// ==================================================
// testbench for the branch prediction unit
// reference model of both tables, directed and random tests
// ==================================================

`timescale 1ns/100ps

`include "bp_macros.svh"

module bp_tb;
	import bp_pkg::*;

	localparam logic [31:0] SEED          = 32'ha0f56b14;
	localparam int          WAIT_LIMIT    = 50;
	localparam int          RANDOM_CYCLES = 2000;

	// PC_A and PC_C share a counter and a buffer slot, PC_B shares the slot only by index
	localparam logic [31:0] PC_A     = 32'h0000_1000;
	localparam logic [31:0] PC_B     = 32'h0000_1080;
	localparam logic [31:0] PC_C     = 32'h0000_2000;
	localparam logic [31:0] TARGET_A = 32'h0000_4a20;
	localparam logic [31:0] TARGET_C = 32'h0000_7f0c;

	logic                clk;
	logic                reset;
	logic                req_valid;
	logic [`BP_PC_W-1:0] req_pc;
	logic                req_ready;
	logic                resp_valid;
	logic                resp_ready;
	logic                resp_taken;
	logic [`BP_PC_W-1:0] resp_target;
	logic                upd_valid;
	logic [`BP_PC_W-1:0] upd_pc;
	update_kind_t        upd_kind;
	logic [`BP_PC_W-1:0] upd_target;

	// ==================================================
	// reference model and bookkeeping
	// ==================================================

	logic [1:0]               model_ctr    [`BP_BHT_ENTRIES];
	logic                     model_valid  [`BP_BTB_ENTRIES];
	logic [`BP_BTB_TAG_W-1:0] model_tag    [`BP_BTB_ENTRIES];
	logic [`BP_PC_W-1:0]      model_target [`BP_BTB_ENTRIES];
	logic [`BP_PC_W:0]        expect_q     [$]; // {taken, target} in request order
	logic [`BP_PC_W:0]        expected;

	logic [`BP_PC_W-1:0] pc_pool [8];
	integer              seed;
	int                  error_count;
	int                  check_count;
	int                  test_count;
	int                  failed_count;
	logic                was_stalled;
	logic                held_taken;
	logic [`BP_PC_W-1:0] held_target;

	branch_predict_unit dut (
		.clk         (clk),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_pc      (req_pc),
		.req_ready   (req_ready),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_taken  (resp_taken),
		.resp_target (resp_target),
		.upd_valid   (upd_valid),
		.upd_pc      (upd_pc),
		.upd_kind    (upd_kind),
		.upd_target  (upd_target)
	);

	always #20 clk = ~clk;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// taken needs an upper-half counter and a matching buffer entry
	function automatic logic [`BP_PC_W:0] compute_prediction(input logic [31:0] pc);
		logic [3:0] slot;
		logic       dir;
		logic       hit;
		slot = pc[5:2];
		dir  = model_ctr[pc[6:2]][1];
		hit  = model_valid[slot] && (model_tag[slot] == pc[31:6]);
		if (dir && hit)
			return {1'b1, model_target[slot]};
		return {1'b0, pc + 32'd4};
	endfunction

	task automatic apply_model_update(input logic [31:0] pc, input update_kind_t kind,
		input logic [31:0] target);
		if (kind == upd_not_taken) begin
			if (model_ctr[pc[6:2]] != 2'd0)
				model_ctr[pc[6:2]] = model_ctr[pc[6:2]] - 2'd1;
		end else begin
			if (model_ctr[pc[6:2]] != 2'd3)
				model_ctr[pc[6:2]] = model_ctr[pc[6:2]] + 2'd1;
			model_valid[pc[5:2]]  = 1'b1;
			model_tag[pc[5:2]]    = pc[31:6];
			model_target[pc[5:2]] = target;
		end
	endtask

	// ==================================================
	// monitor, sampled between edges
	// ==================================================

	always @(negedge clk) begin
		if (!reset) begin
			if (was_stalled) begin
				compare_value("resp_valid", 32'(resp_valid), 32'd1);
				compare_value("resp_taken", 32'(resp_taken), 32'(held_taken));
				compare_value("resp_target", resp_target, held_target);
			end
			was_stalled = resp_valid && !resp_ready;
			held_taken  = resp_taken;
			held_target = resp_target;
			// fetch may hand over a new pc unless a response is held back
			compare_value("req_ready", 32'(req_ready), 32'(!was_stalled));
			if (resp_valid && resp_ready) begin
				if (expect_q.size() == 0) begin
					$display("a response was handed over with no request outstanding");
					error_count++;
				end else begin
					expected = expect_q.pop_front();
					compare_value("resp_taken", 32'(resp_taken), 32'(expected[32]));
					compare_value("resp_target", resp_target, expected[31:0]);
				end
			end
			// the prediction is taken before this edge's update reaches the model
			if (req_valid && req_ready)
				expect_q.push_back(compute_prediction(req_pc));
			if (upd_valid)
				apply_model_update(upd_pc, upd_kind, upd_target);
		end
	end

	// ==================================================
	// stimulus tasks
	// ==================================================

	task automatic lookup(input logic [31:0] pc, output logic taken,
		output logic [31:0] target);
		int waited;
		waited = 0;
		@(posedge clk);
		req_valid <= 1'b1;
		req_pc    <= pc;
		@(negedge clk);
		while (!req_ready && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!req_ready) begin
			$display("the lookup of pc %h was never accepted", pc);
			error_count++;
		end
		@(posedge clk);
		req_valid <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!(resp_valid && resp_ready) && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!(resp_valid && resp_ready)) begin
			$display("no response arrived for the lookup of pc %h", pc);
			error_count++;
		end
		taken  = resp_taken;
		target = resp_target;
		@(posedge clk);
	endtask

	task automatic expect_lookup(input logic [31:0] pc, input logic exp_taken,
		input logic [31:0] exp_target);
		logic        taken;
		logic [31:0] target;
		lookup(pc, taken, target);
		compare_value("resp_taken", 32'(taken), 32'(exp_taken));
		compare_value("resp_target", target, exp_target);
	endtask

	task automatic send_update(input logic [31:0] pc, input update_kind_t kind,
		input logic [31:0] target, input int count);
		repeat (count) begin
			@(posedge clk);
			upd_valid  <= 1'b1;
			upd_pc     <= pc;
			upd_kind   <= kind;
			upd_target <= target;
		end
		@(posedge clk);
		upd_valid <= 1'b0;
	endtask

	// a pending request keeps its pc until it is accepted
	task automatic run_random(input int cycles, input logic stretches);
		logic [31:0] rnd;
		logic [31:0] rnd_target;
		logic        accepted;
		int          hold;
		hold = 0;
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			accepted = req_valid && req_ready;
			@(posedge clk);
			rnd        = $random(seed);
			rnd_target = $random(seed);
			if (!req_valid || accepted) begin
				req_valid <= rnd[0] | rnd[1];
				req_pc    <= pc_pool[rnd[4:2]];
			end
			upd_valid  <= rnd[5];
			upd_pc     <= pc_pool[rnd[8:6]];
			upd_target <= {rnd_target[31:2], 2'b00};
			case (rnd[10:9])
				2'd0:    upd_kind <= upd_not_taken;
				2'd1:    upd_kind <= upd_jump;
				default: upd_kind <= upd_taken;
			endcase
			if (!stretches) begin
				resp_ready <= rnd[11] | rnd[12];
			end else if (hold == 0) begin
				resp_ready <= rnd[11];
				hold = int'(rnd[15:12]) + 1;
			end else begin
				hold--;
			end
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		req_valid  <= 1'b0;
		upd_valid  <= 1'b0;
		resp_ready <= 1'b1;
		@(negedge clk);
		while ((resp_valid || expect_q.size() != 0) && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (resp_valid || expect_q.size() != 0) begin
			$display("%0d responses were still outstanding after the drain", expect_q.size());
			error_count++;
		end
		@(posedge clk);
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			failed_count++;
			$display("test %0d %s: failed with %0d errors", num, name,
				error_count - errors_before);
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		int start_errors;
		clk         = 1'b0;
		reset       = 1'b1;
		req_valid   = 1'b0;
		req_pc      = '0;
		resp_ready  = 1'b1;
		upd_valid   = 1'b0;
		upd_pc      = '0;
		upd_kind    = upd_not_taken;
		upd_target  = '0;
		seed        = SEED;
		was_stalled = 1'b0;
		pc_pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1040, 32'h0000_1080,
			32'h0000_2000, 32'h0000_2008, 32'h0000_3010, 32'h0000_307c};
		for (int i = 0; i < `BP_BHT_ENTRIES; i++)
			model_ctr[i] = 2'd0;
		for (int i = 0; i < `BP_BTB_ENTRIES; i++)
			model_valid[i] = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		start_errors = error_count;
		expect_lookup(32'h0000_1000, 1'b0, 32'h0000_1004);
		expect_lookup(32'h0000_2048, 1'b0, 32'h0000_204c);
		expect_lookup(32'h0000_10fc, 1'b0, 32'h0000_1100);
		expect_lookup(32'hffff_fffc, 1'b0, 32'h0000_0000); // pc plus 4 wraps around
		report_test(1, "lookups after reset", start_errors);

		// a wrapping counter would end up on the other side of the threshold
		start_errors = error_count;
		send_update(PC_A, upd_taken, TARGET_A, 1);
		expect_lookup(PC_A, 1'b0, PC_A + 32'd4);
		send_update(PC_A, upd_taken, TARGET_A, 1);
		expect_lookup(PC_A, 1'b1, TARGET_A);
		send_update(PC_A, upd_jump, TARGET_A, 4);
		expect_lookup(PC_A, 1'b1, TARGET_A);
		send_update(PC_A, upd_not_taken, 32'd0, 1);
		expect_lookup(PC_A, 1'b1, TARGET_A);
		send_update(PC_A, upd_not_taken, 32'd0, 1);
		expect_lookup(PC_A, 1'b0, PC_A + 32'd4);
		send_update(PC_A, upd_not_taken, 32'd0, 4);
		send_update(PC_A, upd_taken, TARGET_A, 1);
		expect_lookup(PC_A, 1'b0, PC_A + 32'd4);
		report_test(2, "counter training and saturation", start_errors);

		start_errors = error_count;
		send_update(PC_C, upd_jump, TARGET_C, 2);
		expect_lookup(PC_C, 1'b1, TARGET_C);
		expect_lookup(PC_A, 1'b0, PC_A + 32'd4); // slot now holds the tag of PC_C
		expect_lookup(PC_B, 1'b0, PC_B + 32'd4);
		send_update(PC_A, upd_not_taken, 32'd0, 2);
		expect_lookup(PC_C, 1'b0, PC_C + 32'd4);
		report_test(3, "aliasing", start_errors);

		start_errors = error_count;
		run_random(300, 1'b1);
		drain();
		report_test(4, "back-pressure", start_errors);

		start_errors = error_count;
		run_random(RANDOM_CYCLES, 1'b0);
		drain();
		report_test(5, "random mixed run", start_errors);

		$display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, failed_count,
			check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verilog/branch_predict_unit.sv ====
// ==================================================
// branch prediction unit top level
// lookup handshake stage, history table and target buffer
// ==================================================

`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_predict_unit (
	input  logic                 clk,
	input  logic                 reset,

	// lookup request from fetch
	input  logic                 req_valid,
	input  logic [`BP_PC_W-1:0]  req_pc,
	output logic                 req_ready,

	// prediction back to fetch
	output logic                 resp_valid,
	input  logic                 resp_ready,
	output logic                 resp_taken,
	output logic [`BP_PC_W-1:0]  resp_target,

	// resolved transfer from execute
	input  logic                 upd_valid,
	input  logic [`BP_PC_W-1:0]  upd_pc,
	input  bp_pkg::update_kind_t upd_kind,
	input  logic [`BP_PC_W-1:0]  upd_target
);
	import bp_pkg::*;

	logic                req_accept;
	logic [`BP_PC_W-1:0] req_pc_q;
	logic                bht_taken;
	logic                btb_hit;
	logic [`BP_PC_W-1:0] btb_target;

	bp_update_if upd_bus ();

	// ==================================================
	// update bus packing
	// ==================================================

	assign upd_bus.valid  = upd_valid;
	assign upd_bus.pc     = upd_pc;
	assign upd_bus.kind   = upd_kind;
	assign upd_bus.target = upd_target;

	// ==================================================
	// lookup stage
	// ==================================================

	// one lookup in flight, a new one may enter as the old one leaves
	assign req_ready  = !resp_valid || resp_ready;
	assign req_accept = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else if (req_accept) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0; // response taken and nothing new came in
		end
	end

	always_ff @(posedge clk) begin
		if (req_accept) begin
			req_pc_q <= req_pc;
		end
	end

	// tables read only on an accepted request, so a stalled response holds
	branch_history_table u_bht (
		.clk   (clk),
		.reset (reset),
		.rd_en (req_accept),
		.rd_pc (req_pc),
		.upd   (upd_bus.sink),
		.taken (bht_taken)
	);

	branch_target_buffer u_btb (
		.clk    (clk),
		.reset  (reset),
		.rd_en  (req_accept),
		.rd_pc  (req_pc),
		.upd    (upd_bus.sink),
		.hit    (btb_hit),
		.target (btb_target)
	);

	// ==================================================
	// response forming
	// ==================================================

	// predict taken only when a target is known
	assign resp_taken  = bht_taken && btb_hit;
	assign resp_target = resp_taken ? btb_target : req_pc_q + `BP_PC_W'(4);

	// a stalled response must not change under fetch
	assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=>
			resp_valid && $stable(resp_taken) && $stable(resp_target))
		else $error("branch_predict_unit: response changed under back-pressure");

endmodule

// ==== vlog.f ====
+incdir+common
common/bp_pkg.sv
common/bp_update_if.sv
branch_predictor/branch_history_table.sv
branch_predictor/branch_target_buffer.sv
verilog/branch_predict_unit.sv
testbench/bp_tb.sv
